/* rtl/bpu_consts.svh */
// pc bits [1:0] are ignored; tag width plus btb index width must equal pc width minus 2
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// pc and operand width
`define BPU_PC_W      32

// pht index is pc[11:2]
`define BPU_PHT_IDX_W 10
`define BPU_PHT_DEPTH (1 << `BPU_PHT_IDX_W)

// btb index is pc[7:2]
`define BPU_BTB_IDX_W 6
`define BPU_BTB_DEPTH (1 << `BPU_BTB_IDX_W)

// btb tag is pc[31:8]
`define BPU_TAG_W     24

`endif

/* rtl/isa_pkg.sv */
// only branch compare opcodes; jumps arrive as BR_JMP with base and offset already chosen
package isa_pkg;

    // opcode sent with every resolve request
    // encoding 3'd7 is unused and resolves as not taken
    typedef enum logic [2:0] {
        BR_JMP = 3'd0, // unconditional
        BR_EQ  = 3'd1,
        BR_NE  = 3'd2,
        BR_LT  = 3'd3, // signed
        BR_GE  = 3'd4, // signed
        BR_LTU = 3'd5,
        BR_GEU = 3'd6
    } br_op_e;

endpackage

/* rtl/pred_pkg.sv */
// counter encoding is fixed: bit 1 is the predicted direction, no wrap between ends
package pred_pkg;

    // 2-bit saturating counter
    typedef enum logic [1:0] {
        CTR_SNT = 2'd0, // strongly not taken
        CTR_WNT = 2'd1, // reset value
        CTR_WT  = 2'd2,
        CTR_ST  = 2'd3  // strongly taken
    } ctr_state_e;

    // resolve handshake sequencer
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0, // wait for req
        ST_EXEC = 2'd1, // single table write
        ST_ACK  = 2'd2, // results held, ack high
        ST_DROP = 2'd3  // ack low before next req
    } ctrl_state_e;

endpackage

/* rtl/pred_upd_if.sv */
// one write per table per cycle; btb fields are don't care while btb_we is low
`timescale 1ns/1ps
`include "bpu_consts.svh"

interface pred_upd_if import pred_pkg::*; ();

    // pht write port
    logic                      pht_we;
    logic [`BPU_PHT_IDX_W-1:0] pht_idx;
    ctr_state_e                pht_wdata;   // already saturated

    // btb write port, always sets valid
    logic                      btb_we;
    logic [`BPU_BTB_IDX_W-1:0] btb_idx;
    logic [`BPU_TAG_W-1:0]     btb_tag;
    logic [`BPU_PC_W-1:0]      btb_target;

    modport src (
        output pht_we, pht_idx, pht_wdata,
        output btb_we, btb_idx, btb_tag, btb_target
    );

    modport dst (
        input pht_we, pht_idx, pht_wdata,
        input btb_we, btb_idx, btb_tag, btb_target
    );

endinterface

/* rtl/bpu_ctrl.sv */
// four-phase handshake; req must stay high until ack is seen, else the result is lost
`timescale 1ns/1ps

module bpu_ctrl import pred_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic req_i,
    output logic capture_o,
    output logic commit_o,
    output logic ack_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    always_comb begin
        state_d   = state_q;
        capture_o = 1'b0;
        commit_o  = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (req_i) begin
                    capture_o = 1'b1;   // latch request fields
                    state_d   = ST_EXEC;
                end
            end
            ST_EXEC: begin
                commit_o = 1'b1;        // one write cycle
                state_d  = ST_ACK;
            end
            ST_ACK: begin
                if (!req_i) begin
                    state_d = ST_DROP;
                end
            end
            default: begin
                state_d = ST_IDLE;      // ack already low here
            end
        endcase
    end

    // ack is registered so it rises one edge after the table write
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            ack_o   <= 1'b0;
        end else begin
            state_q <= state_d;
            ack_o   <= (state_q == ST_ACK) & req_i;
        end
    end

endmodule

/* rtl/branch_unit.sv */
// counter update starts from the state seen at lookup, not the current table entry
`timescale 1ns/1ps
`include "bpu_consts.svh"

module branch_unit import isa_pkg::*, pred_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 capture_i,
    input  logic                 commit_i,
    input  logic [`BPU_PC_W-1:0] res_pc_i,
    input  br_op_e               res_op_i,
    input  logic [`BPU_PC_W-1:0] res_rs1_i,
    input  logic [`BPU_PC_W-1:0] res_rs2_i,
    input  logic [`BPU_PC_W-1:0] res_base_i,
    input  logic [`BPU_PC_W-1:0] res_offs_i,
    input  logic                 res_pred_taken_i,
    input  logic [`BPU_PC_W-1:0] res_pred_target_i,
    input  ctr_state_e           res_pred_state_i,
    output logic                 taken_o,
    output logic                 flush_o,
    output logic [`BPU_PC_W-1:0] redirect_o,
    pred_upd_if.src              upd
);

    // captured request
    logic [`BPU_PC_W-1:0] pc_q;
    br_op_e               op_q;
    logic [`BPU_PC_W-1:0] rs1_q;
    logic [`BPU_PC_W-1:0] rs2_q;
    logic [`BPU_PC_W-1:0] base_q;
    logic [`BPU_PC_W-1:0] offs_q;
    logic                 pred_taken_q;
    logic [`BPU_PC_W-1:0] pred_target_q;
    ctr_state_e           pred_state_q;

    logic                 taken;
    logic [`BPU_PC_W-1:0] target;
    logic [`BPU_PC_W-1:0] redirect;
    logic                 btb_fix;    // taken and btb gave the wrong answer
    logic                 flush;
    ctr_state_e           next_state;

    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            pc_q          <= res_pc_i;
            op_q          <= res_op_i;
            rs1_q         <= res_rs1_i;
            rs2_q         <= res_rs2_i;
            base_q        <= res_base_i;
            offs_q        <= res_offs_i;
            pred_taken_q  <= res_pred_taken_i;
            pred_target_q <= res_pred_target_i;
            pred_state_q  <= res_pred_state_i;
        end
    end

    // direction from the compare
    always_comb begin
        case (op_q)
            BR_JMP:  taken = 1'b1;
            BR_EQ:   taken = (rs1_q == rs2_q);
            BR_NE:   taken = (rs1_q != rs2_q);
            BR_LT:   taken = ($signed(rs1_q) < $signed(rs2_q));
            BR_GE:   taken = ($signed(rs1_q) >= $signed(rs2_q));
            BR_LTU:  taken = (rs1_q < rs2_q);
            BR_GEU:  taken = (rs1_q >= rs2_q);
            default: taken = 1'b0;
        endcase
    end

    assign target   = base_q + offs_q;
    assign redirect = taken ? target : pc_q + `BPU_PC_W'd4;

    // missing or stale btb entry on a taken branch
    assign btb_fix = taken & (~pred_taken_q | (pred_target_q != target));
    assign flush   = btb_fix | (~taken & pred_taken_q);

    // saturating step, up on taken
    always_comb begin
        case (pred_state_q)
            CTR_SNT: next_state = taken ? CTR_WNT : CTR_SNT;
            CTR_WNT: next_state = taken ? CTR_WT  : CTR_SNT;
            CTR_WT:  next_state = taken ? CTR_ST  : CTR_WNT;
            default: next_state = taken ? CTR_ST  : CTR_WT;
        endcase
    end

    assign upd.pht_we     = commit_i;     // every resolve trains the pht
    assign upd.pht_idx    = pc_q[`BPU_PHT_IDX_W+1:2];
    assign upd.pht_wdata  = next_state;
    assign upd.btb_we     = commit_i & btb_fix;
    assign upd.btb_idx    = pc_q[`BPU_BTB_IDX_W+1:2];
    assign upd.btb_tag    = pc_q[`BPU_PC_W-1:`BPU_PC_W-`BPU_TAG_W];
    assign upd.btb_target = target;

    // results hold until the next commit
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            taken_o <= 1'b0;
            flush_o <= 1'b0;
        end else if (commit_i) begin
            taken_o <= taken;
            flush_o <= flush;
        end
    end

    always_ff @(posedge clk_i) begin
        if (commit_i) begin
            redirect_o <= redirect;
        end
    end

endmodule

/* rtl/pht_table.sv */
// all counters reset to weakly not taken; a write and a read of one index in a cycle reads old
`timescale 1ns/1ps
`include "bpu_consts.svh"

module pht_table import pred_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [`BPU_PHT_IDX_W-1:0] rd_idx_i,
    output ctr_state_e                rd_state_o,
    pred_upd_if.dst                   upd
);

    ctr_state_e ctr_q [`BPU_PHT_DEPTH];

    // lookup path, no clock
    assign rd_state_o = ctr_q[rd_idx_i];

    // write data is already saturated by the branch unit
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BPU_PHT_DEPTH; i++) begin
                ctr_q[i] <= CTR_WNT;
            end
        end else if (upd.pht_we) begin
            ctr_q[upd.pht_idx] <= upd.pht_wdata;
        end
    end

endmodule

/* rtl/btb_table.sv */
// direct mapped, no replacement choice; only valid bits reset, entries are never invalidated
`timescale 1ns/1ps
`include "bpu_consts.svh"

module btb_table (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [`BPU_BTB_IDX_W-1:0] rd_idx_i,
    input  logic [`BPU_TAG_W-1:0]     rd_tag_i,
    output logic                      hit_o,
    output logic [`BPU_PC_W-1:0]      target_o,
    pred_upd_if.dst                   upd
);

    logic [`BPU_BTB_DEPTH-1:0] valid_q;
    logic [`BPU_TAG_W-1:0]     tag_q    [`BPU_BTB_DEPTH];
    logic [`BPU_PC_W-1:0]      target_q [`BPU_BTB_DEPTH];

    // lookup with tag compare
    assign hit_o    = valid_q[rd_idx_i] & (tag_q[rd_idx_i] == rd_tag_i);
    assign target_o = target_q[rd_idx_i];   // only meaningful on hit

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (upd.btb_we) begin
            valid_q[upd.btb_idx] <= 1'b1;
        end
    end

    // payload, overwritten on alias
    always_ff @(posedge clk_i) begin
        if (upd.btb_we) begin
            tag_q[upd.btb_idx]    <= upd.btb_tag;
            target_q[upd.btb_idx] <= upd.btb_target;
        end
    end

endmodule

/* rtl/bpu_top.sv */
// lookup is combinational and sees a resolve's writes only after res_ack_o rises
`timescale 1ns/1ps
`include "bpu_consts.svh"

module bpu_top import isa_pkg::*, pred_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // fetch lookup
    input  logic [`BPU_PC_W-1:0] fetch_pc_i,
    output logic                 pred_hit_o,
    output logic                 pred_taken_o,
    output logic [`BPU_PC_W-1:0] pred_target_o,
    output ctr_state_e           pred_state_o,
    // resolve request
    input  logic                 res_req_i,
    input  logic [`BPU_PC_W-1:0] res_pc_i,
    input  br_op_e               res_op_i,
    input  logic [`BPU_PC_W-1:0] res_rs1_i,
    input  logic [`BPU_PC_W-1:0] res_rs2_i,
    input  logic [`BPU_PC_W-1:0] res_base_i,
    input  logic [`BPU_PC_W-1:0] res_offs_i,
    input  logic                 res_pred_taken_i,
    input  logic [`BPU_PC_W-1:0] res_pred_target_i,
    input  ctr_state_e           res_pred_state_i,
    // resolve result, valid while ack is high
    output logic                 res_ack_o,
    output logic                 res_taken_o,
    output logic                 res_flush_o,
    output logic [`BPU_PC_W-1:0] res_redirect_o
);

    logic                      capture;
    logic                      commit;
    logic [`BPU_PHT_IDX_W-1:0] pht_idx;
    logic [`BPU_BTB_IDX_W-1:0] btb_idx;
    logic [`BPU_TAG_W-1:0]     fetch_tag;
    logic [`BPU_PC_W-1:0]      btb_target;

    pred_upd_if upd_bus ();

    assign pht_idx   = fetch_pc_i[`BPU_PHT_IDX_W+1:2];
    assign btb_idx   = fetch_pc_i[`BPU_BTB_IDX_W+1:2];
    assign fetch_tag = fetch_pc_i[`BPU_PC_W-1:`BPU_PC_W-`BPU_TAG_W];

    bpu_ctrl u_ctrl (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (res_req_i),
        .capture_o (capture),
        .commit_o  (commit),
        .ack_o     (res_ack_o)
    );

    branch_unit u_branch (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .capture_i         (capture),
        .commit_i          (commit),
        .res_pc_i          (res_pc_i),
        .res_op_i          (res_op_i),
        .res_rs1_i         (res_rs1_i),
        .res_rs2_i         (res_rs2_i),
        .res_base_i        (res_base_i),
        .res_offs_i        (res_offs_i),
        .res_pred_taken_i  (res_pred_taken_i),
        .res_pred_target_i (res_pred_target_i),
        .res_pred_state_i  (res_pred_state_i),
        .taken_o           (res_taken_o),
        .flush_o           (res_flush_o),
        .redirect_o        (res_redirect_o),
        .upd               (upd_bus.src)
    );

    pht_table u_pht (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rd_idx_i   (pht_idx),
        .rd_state_o (pred_state_o),
        .upd        (upd_bus.dst)
    );

    btb_table u_btb (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .rd_idx_i (btb_idx),
        .rd_tag_i (fetch_tag),
        .hit_o    (pred_hit_o),
        .target_o (btb_target),
        .upd      (upd_bus.dst)
    );

    // taken needs a btb hit, otherwise fall through
    assign pred_taken_o  = pred_hit_o & pred_state_o[1];
    assign pred_target_o = pred_hit_o ? btb_target : fetch_pc_i + `BPU_PC_W'd4;

endmodule

/* dv/bpu_checker.sv */
// samples on the rising clock; the write enables are taken from the update interface in bpu_top
`timescale 1ns/1ps

module bpu_checker (
    input logic clk_i,
    input logic rst_n_i,
    input logic req_i,
    input logic ack_i,
    input logic pht_we_i,
    input logic btb_we_i
);

    int unsigned fail_cnt = 0;  // failed assertion count

    // ack only answers a held request
    a_ack_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> $past(req_i))
        else begin
            fail_cnt++;
            $error("ack rose while req was low");
        end

    a_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(ack_i) |-> $past(!req_i))
        else begin
            fail_cnt++;
            $error("ack fell while req was still high");
        end

    // exactly one pht write, two edges before ack rises
    a_one_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> $past(pht_we_i, 2) && !$past(pht_we_i))
        else begin
            fail_cnt++;
            $error("handshake without exactly one pht write");
        end

    a_write_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pht_we_i |=> !pht_we_i)
        else begin
            fail_cnt++;
            $error("pht write enable held for more than one cycle");
        end

    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |-> !ack_i && !pht_we_i && !btb_we_i)
        else begin
            fail_cnt++;
            $error("ack or a write enable high during reset");
        end

endmodule

bind bpu_top bpu_checker u_checker (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (res_req_i),
    .ack_i    (res_ack_o),
    .pht_we_i (upd_bus.pht_we),
    .btb_we_i (upd_bus.btb_we)
);

/* dv/bpu_tb.sv */
// one resolve in flight at a time; lookups are checked only while no handshake is open
`timescale 1ns/1ps
`include "bpu_consts.svh"

module bpu_tb import isa_pkg::*, pred_pkg::*; ();

    localparam int MAX_RESOLVES   = 400;
    localparam int TIMEOUT_CYCLES = MAX_RESOLVES * 8 + 200;  // worst case 8 cycles per resolve
    localparam int N_RANDOM       = 300;

    typedef struct packed {
        logic                 taken;
        logic                 flush;
        logic [`BPU_PC_W-1:0] redirect;
    } result_t;

    logic                 clk_i;
    logic                 rst_n_i;
    logic [`BPU_PC_W-1:0] fetch_pc_i;
    logic                 pred_hit_o;
    logic                 pred_taken_o;
    logic [`BPU_PC_W-1:0] pred_target_o;
    ctr_state_e           pred_state_o;
    logic                 res_req_i;
    logic [`BPU_PC_W-1:0] res_pc_i;
    br_op_e               res_op_i;
    logic [`BPU_PC_W-1:0] res_rs1_i;
    logic [`BPU_PC_W-1:0] res_rs2_i;
    logic [`BPU_PC_W-1:0] res_base_i;
    logic [`BPU_PC_W-1:0] res_offs_i;
    logic                 res_pred_taken_i;
    logic [`BPU_PC_W-1:0] res_pred_target_i;
    ctr_state_e           res_pred_state_i;
    logic                 res_ack_o;
    logic                 res_taken_o;
    logic                 res_flush_o;
    logic [`BPU_PC_W-1:0] res_redirect_o;

    // reference tables
    ctr_state_e            m_ctr    [`BPU_PHT_DEPTH];
    logic                  m_valid  [`BPU_BTB_DEPTH];
    logic [`BPU_TAG_W-1:0] m_tag    [`BPU_BTB_DEPTH];
    logic [`BPU_PC_W-1:0]  m_target [`BPU_BTB_DEPTH];

    result_t exp_q [$];
    string   test_name = "reset";
    int      n_sent    = 0;
    int      n_checked = 0;
    int      cycles    = 0;
    logic    ack_seen  = 1'b0;

    bpu_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("error in %s, %s expected %0b actual %0b",
                                    test_name, what, exp, act));
        end
    endtask

    task automatic check_addr(input string what, input logic [`BPU_PC_W-1:0] exp,
                              input logic [`BPU_PC_W-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("error in %s, %s expected %h actual %h",
                                    test_name, what, exp, act));
        end
    endtask

    task automatic check_state(input string what, input ctr_state_e exp, input ctr_state_e act);
        if (act !== exp) begin
            stop_on_error($sformatf("error in %s, %s expected %s actual %s",
                                    test_name, what, exp.name(), act.name()));
        end
    endtask

    function automatic logic branch_taken(input br_op_e op, input logic [`BPU_PC_W-1:0] a,
                                          input logic [`BPU_PC_W-1:0] b);
        logic [`BPU_PC_W-1:0] sa;
        logic [`BPU_PC_W-1:0] sb;
        // signed order is unsigned order with the sign bits flipped
        sa = a ^ {1'b1, {(`BPU_PC_W-1){1'b0}}};
        sb = b ^ {1'b1, {(`BPU_PC_W-1){1'b0}}};
        case (op)
            BR_JMP:  return 1'b1;
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return sa < sb;
            BR_GE:   return !(sa < sb);
            BR_LTU:  return a < b;
            BR_GEU:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic result_t model_resolve(
        input  logic [`BPU_PC_W-1:0] pc,
        input  br_op_e               op,
        input  logic [`BPU_PC_W-1:0] rs1,
        input  logic [`BPU_PC_W-1:0] rs2,
        input  logic [`BPU_PC_W-1:0] target,
        input  logic                 p_taken,
        input  logic [`BPU_PC_W-1:0] p_target,
        input  ctr_state_e           p_state,
        output ctr_state_e           new_state
    );
        result_t r;
        r.taken    = branch_taken(op, rs1, rs2);
        r.redirect = r.taken ? target : pc + 32'd4;
        r.flush    = r.taken ? (!p_taken || p_target != target) : p_taken;
        if (r.taken && p_state != CTR_ST) begin
            new_state = ctr_state_e'(p_state + 2'd1);
        end else if (!r.taken && p_state != CTR_SNT) begin
            new_state = ctr_state_e'(p_state - 2'd1);
        end else begin
            new_state = p_state;  // saturated
        end
        m_ctr[pc[11:2]] = new_state;
        if (r.taken && r.flush) begin
            m_valid[pc[7:2]]  = 1'b1;
            m_tag[pc[7:2]]    = pc[31:8];
            m_target[pc[7:2]] = target;
        end
        return r;
    endfunction

    task automatic lookup(input logic [`BPU_PC_W-1:0] pc);
        logic hit;
        hit = m_valid[pc[7:2]] && (m_tag[pc[7:2]] == pc[31:8]);
        @(negedge clk_i);
        fetch_pc_i = pc;
        @(posedge clk_i);
        check_bit("hit", hit, pred_hit_o);
        check_state("lookup state", m_ctr[pc[11:2]], pred_state_o);
        check_bit("predicted taken", hit && (m_ctr[pc[11:2]] >= CTR_WT), pred_taken_o);
        check_addr("predicted target", hit ? m_target[pc[7:2]] : pc + 32'd4, pred_target_o);
    endtask

    task automatic run_branch(
        input logic [`BPU_PC_W-1:0] pc,
        input br_op_e               op,
        input logic [`BPU_PC_W-1:0] rs1,
        input logic [`BPU_PC_W-1:0] rs2,
        input logic [`BPU_PC_W-1:0] base,
        input logic [`BPU_PC_W-1:0] offs,
        input int                   hold
    );
        result_t    exp;
        ctr_state_e new_state;
        lookup(pc);
        exp = model_resolve(pc, op, rs1, rs2, base + offs, pred_taken_o, pred_target_o,
                            pred_state_o, new_state);
        exp_q.push_back(exp);
        n_sent++;
        @(negedge clk_i);
        res_pc_i          = pc;
        res_op_i          = op;
        res_rs1_i         = rs1;
        res_rs2_i         = rs2;
        res_base_i        = base;
        res_offs_i        = offs;
        res_pred_taken_i  = pred_taken_o;
        res_pred_target_i = pred_target_o;
        res_pred_state_i  = pred_state_o;
        res_req_i         = 1'b1;
        do @(negedge clk_i); while (!res_ack_o);
        repeat (hold) @(negedge clk_i);
        res_req_i = 1'b0;
        do @(negedge clk_i); while (res_ack_o);
        check_state("updated state", new_state, pred_state_o);  // fetch pc unchanged
    endtask

    // results are compared once per rising ack
    always @(negedge clk_i) begin : compare_results
        result_t exp;
        if (rst_n_i && res_ack_o && !ack_seen) begin
            if (exp_q.size() == 0) begin
                stop_on_error("acknowledge arrived with no request outstanding");
            end else begin
                exp = exp_q.pop_front();
                check_bit("taken", exp.taken, res_taken_o);
                check_bit("flush", exp.flush, res_flush_o);
                check_addr("redirect", exp.redirect, res_redirect_o);
                n_checked++;
            end
        end
        ack_seen = res_ack_o;
    end

    always @(negedge clk_i) begin : watchdog
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_on_error("timeout, the resolve handshakes did not finish in time");
        end else if (UUT.u_checker.fail_cnt != 0) begin
            stop_on_error("a handshake or table write assertion fired");
        end
    end

    initial begin : stimulus
        logic [`BPU_PC_W-1:0] pc;
        br_op_e               op;
        logic [`BPU_PC_W-1:0] rs1;
        logic [`BPU_PC_W-1:0] rs2;
        logic [`BPU_PC_W-1:0] base;
        logic [`BPU_PC_W-1:0] offs;
        void'($urandom(32'h24e));
        rst_n_i           = 1'b0;
        fetch_pc_i        = '0;
        res_req_i         = 1'b0;
        res_pc_i          = '0;
        res_op_i          = BR_JMP;
        res_rs1_i         = '0;
        res_rs2_i         = '0;
        res_base_i        = '0;
        res_offs_i        = '0;
        res_pred_taken_i  = 1'b0;
        res_pred_target_i = '0;
        res_pred_state_i  = CTR_WNT;
        for (int i = 0; i < `BPU_PHT_DEPTH; i++) begin
            m_ctr[i] = CTR_WNT;
        end
        for (int i = 0; i < `BPU_BTB_DEPTH; i++) begin
            m_valid[i] = 1'b0;
        end
        repeat (3) @(negedge clk_i);
        rst_n_i = 1'b1;

        // empty tables after reset
        for (int i = 0; i < 8; i++) begin
            lookup($urandom());
        end

        test_name = "opcodes";
        run_branch(32'h2000, BR_JMP, 32'h0, 32'h0, 32'h2400, 32'h10, 0);
        run_branch(32'h2004, BR_EQ, 32'h5, 32'h5, 32'h2400, 32'hffff_fff0, 1);
        run_branch(32'h2008, BR_EQ, 32'h5, 32'h6, 32'h2400, 32'h10, 0);
        run_branch(32'h200c, BR_NE, 32'h5, 32'h6, 32'h2400, 32'h20, 2);
        run_branch(32'h2010, BR_NE, 32'h9, 32'h9, 32'h2400, 32'h20, 0);
        run_branch(32'h2014, BR_LT, 32'hffff_ffff, 32'h1, 32'h2400, 32'h30, 0);
        run_branch(32'h2018, BR_LTU, 32'hffff_ffff, 32'h1, 32'h2400, 32'h30, 1);
        run_branch(32'h201c, BR_GE, 32'hffff_ffff, 32'h1, 32'h2400, 32'h40, 0);
        run_branch(32'h2020, BR_GEU, 32'hffff_ffff, 32'h1, 32'h2400, 32'h40, 0);
        run_branch(32'h2024, BR_LT, 32'h8000_0000, 32'h7fff_ffff, 32'h2400, 32'h50, 0);
        run_branch(32'h2028, BR_LTU, 32'h1, 32'hffff_ffff, 32'h2400, 32'h50, 1);
        run_branch(32'h202c, BR_GE, 32'h7, 32'h7, 32'h2400, 32'h60, 0);
        run_branch(32'h2030, BR_GEU, 32'h0, 32'h0, 32'h2400, 32'h60, 0);
        run_branch(32'h2034, BR_GE, 32'h1, 32'h8000_0000, 32'h2400, 32'h70, 0);

        test_name = "saturate";
        repeat (5) begin
            run_branch(32'h3000, BR_JMP, 32'h0, 32'h0, 32'h3800, 32'h0, 1);
        end
        check_state("top of range", CTR_ST, pred_state_o);
        repeat (5) begin
            run_branch(32'h3000, BR_NE, 32'h7, 32'h7, 32'h3800, 32'h0, 0);
        end
        check_state("bottom of range", CTR_SNT, pred_state_o);

        test_name = "btb fill";
        run_branch(32'h4000, BR_JMP, 32'h0, 32'h0, 32'h8000, 32'h40, 0);
        check_bit("flush on fill", 1'b1, res_flush_o);
        lookup(32'h4000);
        check_bit("hit after fill", 1'b1, pred_hit_o);
        check_addr("filled target", 32'h8040, pred_target_o);
        // second pass trains the counter so the new target meets a taken prediction
        run_branch(32'h4000, BR_JMP, 32'h0, 32'h0, 32'h8000, 32'h40, 0);
        lookup(32'h4000);
        check_bit("taken before target change", 1'b1, pred_taken_o);
        run_branch(32'h4000, BR_JMP, 32'h0, 32'h0, 32'h9000, 32'h0, 0);
        check_bit("flush on new target", 1'b1, res_flush_o);
        lookup(32'h4000);
        check_addr("replaced target", 32'h9000, pred_target_o);

        test_name = "wrong direction";
        run_branch(32'h4000, BR_EQ, 32'h1, 32'h2, 32'h9000, 32'h0, 0);
        check_bit("flush on not taken", 1'b1, res_flush_o);
        lookup(32'h4000);
        check_bit("entry kept", 1'b1, pred_hit_o);
        check_addr("kept target", 32'h9000, pred_target_o);

        // bits 13:12 alias both tables, bits 9:8 alias the btb only
        test_name = "random";
        for (int n = 0; n < N_RANDOM; n++) begin
            pc   = 32'h0001_0000 | ($urandom_range(3) << 12) | ($urandom_range(3) << 8)
                   | ($urandom_range(7) << 2);
            op   = br_op_e'(3'($urandom_range(6)));
            rs1  = $urandom();
            rs2  = ($urandom_range(3) == 0) ? rs1 : $urandom();
            base = 32'h0002_0000 | ($urandom_range(3) << 4);
            offs = ($urandom_range(1) == 0) ? 32'h0 : 32'h100;
            run_branch(pc, op, rs1, rs2, base, offs, $urandom_range(2));
        end

        if (n_checked == n_sent && exp_q.size() == 0 && UUT.u_checker.fail_cnt == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            stop_on_error("not every resolve was compared, or an assertion fired");
        end
    end

endmodule

/* bpu.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/pred_pkg.sv
rtl/pred_upd_if.sv
rtl/bpu_ctrl.sv
rtl/branch_unit.sv
rtl/pht_table.sv
rtl/btb_table.sv
rtl/bpu_top.sv
dv/bpu_checker.sv
dv/bpu_tb.sv

/* Makefile */
TOOL   := verilator
FLAGS  := --binary --timing --assert -j 0
LINT   := --lint-only --timing --assert
TOP    := bpu_tb
FLIST  := bpu.f
OBJDIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR) -o $(TOP)
	@out="$$(./$(OBJDIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJDIR)
